/* sdi_video_pkg.sv */
//----------------------------------------------------------------------
// SDI stream word, line number and receiver mode types plus the video
// test pattern constants; imported by every RTL block of the checker
//----------------------------------------------------------------------

package sdi_video_pkg;

  localparam int unsigned NUM_DS = 4;            // data streams handled

  // TRS status word, bit 9 down to bit 0
  typedef struct packed {
    logic       one;
    logic       f;                               // field
    logic       v;                               // vertical blanking
    logic       h;                               // 1 = EAV, 0 = SAV
    logic [3:0] prot;                            // protection bits
    logic [1:0] lsb;
  } sdi_xyz_t;

  typedef union packed {
    logic [9:0] raw;
    sdi_xyz_t   xyz;
  } sdi_word_t;

  typedef sdi_word_t [NUM_DS-1:0] sdi_words_t;

  typedef logic [10:0] line_num_t;
  typedef line_num_t [NUM_DS-1:0] sdi_lines_t;

  typedef enum logic [2:0] {
    MODE_HD   = 3'b000,
    MODE_SD   = 3'b001,
    MODE_3G   = 3'b010,
    MODE_6G   = 3'b100,
    MODE_12G  = 3'b101,
    MODE_12GF = 3'b110                           // 12G at 1000/1001
  } sdi_mode_t;

  localparam logic [9:0] PAT_EVEN = 10'h3AC;     // streams 0 and 2
  localparam logic [9:0] PAT_ODD  = 10'h3C0;     // streams 1 and 3

  localparam int unsigned CRC_SLOT = 8;          // EAV is position 1

  function automatic logic [NUM_DS-1:0] stream_mask(input logic [2:0] code);
    case (code)
      3'd0:    return 4'b0001;
      3'd1:    return 4'b0011;
      3'd2,
      3'd3,
      3'd4:    return 4'b1111;
      default: return 4'b0001;
    endcase
  endfunction

endpackage

/* sdi_check_pkg.sv */
//----------------------------------------------------------------------
// Error counter width, saturating add and the transport format type
// shared by the lock monitor and the three stream checkers
//----------------------------------------------------------------------

package sdi_check_pkg;

  localparam int unsigned ERR_CNT_W = 16;

  typedef struct packed {
    logic [3:0] family;
    logic [3:0] rate;
    logic       scan;                            // 1 = progressive
  } xport_fmt_t;

  // counters stick at all ones
  function automatic logic [ERR_CNT_W-1:0] sat_add(input logic [ERR_CNT_W-1:0] cnt,
                                                   input logic [ERR_CNT_W-1:0] inc);
    logic [ERR_CNT_W:0] sum;
    sum = {1'b0, cnt} + {1'b0, inc};
    return sum[ERR_CNT_W] ? '1 : sum[ERR_CNT_W-1:0];
  endfunction

endpackage

/* sdi_timing_if.sv */
//----------------------------------------------------------------------
// Line timing from the TRS tracker to the line, pattern and CRC checkers
//----------------------------------------------------------------------

`timescale 1ns/1ps

interface sdi_timing_if import sdi_video_pkg::*; ();

  logic              rx_ce;
  logic [NUM_DS-1:0] active_streams_mask;
  logic              line_start;                 // word after SAV
  logic              active_video;
  logic              trs;
  logic              crc_strobe;                 // CRC slot after EAV

  modport tracker (
    output rx_ce,
    output active_streams_mask,
    output line_start,
    output active_video,
    output trs,
    output crc_strobe
  );

  modport check (
    input rx_ce,
    input active_streams_mask,
    input line_start,
    input active_video,
    input trs,
    input crc_strobe
  );

endinterface

/* sdi_trs_tracker.sv */
//----------------------------------------------------------------------
// Follows EAV/SAV on the receiver outputs and produces line start,
// active video and the CRC slot strobe for the stream checkers
//----------------------------------------------------------------------

`timescale 1ns/1ps

module sdi_trs_tracker import sdi_video_pkg::*; (
  input  logic          clk,
  input  logic          arst_n,
  input  logic          rx_ce,
  input  logic          rx_mode_locked,
  input  logic          rx_eav,
  input  logic          rx_sav,
  input  logic          rx_trs,
  input  sdi_word_t     rx_ds0_word,
  input  logic [2:0]    rx_active_streams,
  input  sdi_mode_t     exp_mode,
  sdi_timing_if.tracker tim
);

  logic       eav_flag;
  logic       sav_flag;
  logic       active_line;
  logic       act_vid;
  logic [3:0] word_cnt;                          // position of last word
  logic [3:0] cur_pos;
  logic       is_eav;
  logic       is_sav;
  logic       sd_mode;

  assign is_eav      = rx_mode_locked & rx_trs & rx_eav;
  assign is_sav      = rx_mode_locked & rx_trs & rx_sav;
  assign sd_mode     = (exp_mode == MODE_SD);
  assign active_line = eav_flag & sav_flag;

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      eav_flag <= 1'b0;
      sav_flag <= 1'b0;
    end
    else if (rx_ce)
    begin
      if (active_line)
      begin
        eav_flag <= 1'b0;                        // one word of line start
        sav_flag <= 1'b0;
      end
      else if (is_eav && !sav_flag)
        eav_flag <= 1'b1;
      else if (is_sav && eav_flag)
        sav_flag <= 1'b1;
    end
  end

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
      act_vid <= 1'b0;
    else if (rx_ce && rx_mode_locked && rx_trs)
      act_vid <= rx_sav & ~rx_ds0_word.xyz.v;    // any other TRS ends it
  end

  // word position after EAV, stuck at 15 until the first EAV
  assign cur_pos = is_eav ? 4'd1 : ((word_cnt == 4'hF) ? word_cnt : word_cnt + 4'd1);

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
      word_cnt <= 4'hF;
    else if (rx_ce && rx_mode_locked)
      word_cnt <= cur_pos;
  end

  assign tim.rx_ce               = rx_ce;
  assign tim.trs                 = rx_trs;
  assign tim.active_streams_mask = stream_mask(rx_active_streams);
  assign tim.active_video        = act_vid;
  assign tim.line_start          = active_line & ~sd_mode;
  assign tim.crc_strobe          = rx_ce & rx_mode_locked & ~sd_mode &
                                   (cur_pos == 4'(CRC_SLOT));

endmodule

/* sdi_lock_monitor.sv */
//----------------------------------------------------------------------
// Delays the receiver lock signals and compares transport format and
// mode once after lock; done and error flags hold until reset
//----------------------------------------------------------------------

`timescale 1ns/1ps

module sdi_lock_monitor import sdi_video_pkg::*, sdi_check_pkg::*; (
  input  logic       clk,
  input  logic       arst_n,
  input  logic       rx_ce,
  input  logic       rx_mode_locked,
  input  logic       rx_t_locked,
  input  xport_fmt_t rx_fmt,
  input  sdi_mode_t  rx_mode,
  input  xport_fmt_t exp_fmt,
  input  sdi_mode_t  exp_mode,
  output logic       fmt_done,
  output logic       fmt_err,
  output logic       mode_done,
  output logic       mode_err
);

  logic [3:0] mode_lock_q;                       // 4 stage delay
  logic [1:0] t_lock_q;                          // 2 stage delay
  logic       fmt_seen;
  logic       fmt_diff;
  logic       mode_seen;
  logic       mode_diff;

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      mode_lock_q <= '0;
      t_lock_q    <= '0;
    end
    else if (rx_ce)
    begin
      mode_lock_q <= {mode_lock_q[2:0], rx_mode_locked};
      t_lock_q    <= {t_lock_q[0], rx_t_locked};
    end
  end

  //--------------------------------------------------------------------
  // one-shot comparisons, flags follow one clock after the compare
  //--------------------------------------------------------------------
  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      fmt_seen  <= 1'b0;
      fmt_diff  <= 1'b0;
      fmt_done  <= 1'b0;
      fmt_err   <= 1'b0;
      mode_seen <= 1'b0;
      mode_diff <= 1'b0;
      mode_done <= 1'b0;
      mode_err  <= 1'b0;
    end
    else
    begin
      if (rx_ce && t_lock_q[1] && !fmt_seen)
      begin
        fmt_seen <= 1'b1;
        fmt_diff <= (rx_fmt != exp_fmt);         // family, rate and scan
      end
      if (rx_ce && mode_lock_q[3] && !mode_seen)
      begin
        mode_seen <= 1'b1;
        mode_diff <= (rx_mode != exp_mode);
      end
      fmt_done  <= fmt_seen;
      fmt_err   <= fmt_err | (fmt_seen & fmt_diff);
      mode_done <= mode_seen;
      mode_err  <= mode_err | (mode_seen & mode_diff);
    end
  end

endmodule

/* sdi_line_checker.sv */
//----------------------------------------------------------------------
// Counts enabled streams whose line number differs from the expected
// line at each line start
//----------------------------------------------------------------------

`timescale 1ns/1ps

module sdi_line_checker import sdi_video_pkg::*, sdi_check_pkg::*; (
  input  logic                 clk,
  input  logic                 arst_n,
  sdi_timing_if.check          tim,
  input  sdi_lines_t           rx_ln,
  input  line_num_t            exp_line,
  output logic [ERR_CNT_W-1:0] line_err_cnt
);

  logic [NUM_DS-1:0] hits;                       // wrong line per stream

  always_comb
  begin
    for (int i = 0; i < NUM_DS; i++)
      hits[i] = tim.active_streams_mask[i] & (rx_ln[i] != exp_line);
  end

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
      line_err_cnt <= '0;
    else if (tim.rx_ce && tim.line_start)
      line_err_cnt <= sat_add(line_err_cnt, ERR_CNT_W'($countones(hits)));
  end

endmodule

/* sdi_pattern_checker.sv */
//----------------------------------------------------------------------
// Compares active video words of the enabled streams with the fixed
// test pattern and counts every differing word
//----------------------------------------------------------------------

`timescale 1ns/1ps

module sdi_pattern_checker import sdi_video_pkg::*, sdi_check_pkg::*; (
  input  logic                 clk,
  input  logic                 arst_n,
  input  logic                 rx_mode_locked,
  sdi_timing_if.check          tim,
  input  sdi_words_t           rx_ds,
  output logic [ERR_CNT_W-1:0] data_err_cnt
);

  logic [NUM_DS-1:0] hits;
  logic              check_en;

  // even streams carry PAT_EVEN, odd streams PAT_ODD
  always_comb
  begin
    for (int i = 0; i < NUM_DS; i++)
      hits[i] = tim.active_streams_mask[i] &
                (rx_ds[i].raw != ((i % 2 == 0) ? PAT_EVEN : PAT_ODD));
  end

  assign check_en = tim.rx_ce & rx_mode_locked & tim.active_video & ~tim.trs;

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
      data_err_cnt <= '0;
    else if (check_en)
      data_err_cnt <= sat_add(data_err_cnt, ERR_CNT_W'($countones(hits)));
  end

endmodule

/* sdi_crc_checker.sv */
//----------------------------------------------------------------------
// Counts CRC error flags of the enabled streams at the CRC slot
//----------------------------------------------------------------------

`timescale 1ns/1ps

module sdi_crc_checker import sdi_video_pkg::*, sdi_check_pkg::*; (
  input  logic                 clk,
  input  logic                 arst_n,
  sdi_timing_if.check          tim,
  input  logic [NUM_DS-1:0]    rx_crc_err,
  output logic [ERR_CNT_W-1:0] crc_err_cnt
);

  logic [NUM_DS-1:0] hits;

  assign hits = tim.active_streams_mask & rx_crc_err;

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
      crc_err_cnt <= '0;
    else if (tim.rx_ce && tim.crc_strobe)
      crc_err_cnt <= sat_add(crc_err_cnt, ERR_CNT_W'($countones(hits)));  // once per line
  end

endmodule

/* sdi_rx_checker.sv */
//----------------------------------------------------------------------
// Receive side SDI checker, sits beside the receiver and counts or
// flags lock, line number, video pattern and CRC errors
//----------------------------------------------------------------------

`timescale 1ns/1ps

module sdi_rx_checker import sdi_video_pkg::*, sdi_check_pkg::*; (
  input  logic                 clk,
  input  logic                 arst_n,
  input  logic                 rx_ce,
  input  logic                 rx_mode_locked,
  input  logic                 rx_t_locked,
  input  xport_fmt_t           rx_fmt,
  input  sdi_mode_t            rx_mode,
  input  logic                 rx_eav,
  input  logic                 rx_sav,
  input  logic                 rx_trs,
  input  sdi_words_t           rx_ds,
  input  sdi_lines_t           rx_ln,
  input  logic [NUM_DS-1:0]    rx_crc_err,
  input  logic [2:0]           rx_active_streams,
  input  xport_fmt_t           exp_fmt,
  input  sdi_mode_t            exp_mode,
  input  line_num_t            exp_line,
  output logic [ERR_CNT_W-1:0] line_err_cnt,
  output logic [ERR_CNT_W-1:0] data_err_cnt,
  output logic [ERR_CNT_W-1:0] crc_err_cnt,
  output logic                 fmt_done,
  output logic                 fmt_err,
  output logic                 mode_done,
  output logic                 mode_err
);

  sdi_timing_if tim ();

  sdi_trs_tracker u_tracker (
    .clk               (clk),
    .arst_n            (arst_n),
    .rx_ce             (rx_ce),
    .rx_mode_locked    (rx_mode_locked),
    .rx_eav            (rx_eav),
    .rx_sav            (rx_sav),
    .rx_trs            (rx_trs),
    .rx_ds0_word       (rx_ds[0]),               // stream 0 carries the timing
    .rx_active_streams (rx_active_streams),
    .exp_mode          (exp_mode),
    .tim               (tim)
  );

  sdi_lock_monitor u_lock (
    .clk            (clk),
    .arst_n         (arst_n),
    .rx_ce          (rx_ce),
    .rx_mode_locked (rx_mode_locked),
    .rx_t_locked    (rx_t_locked),
    .rx_fmt         (rx_fmt),
    .rx_mode        (rx_mode),
    .exp_fmt        (exp_fmt),
    .exp_mode       (exp_mode),
    .fmt_done       (fmt_done),
    .fmt_err        (fmt_err),
    .mode_done      (mode_done),
    .mode_err       (mode_err)
  );

  sdi_line_checker u_line (
    .clk          (clk),
    .arst_n       (arst_n),
    .tim          (tim),
    .rx_ln        (rx_ln),
    .exp_line     (exp_line),
    .line_err_cnt (line_err_cnt)
  );

  sdi_pattern_checker u_pattern (
    .clk            (clk),
    .arst_n         (arst_n),
    .rx_mode_locked (rx_mode_locked),
    .tim            (tim),
    .rx_ds          (rx_ds),
    .data_err_cnt   (data_err_cnt)
  );

  sdi_crc_checker u_crc (
    .clk         (clk),
    .arst_n      (arst_n),
    .tim         (tim),
    .rx_crc_err  (rx_crc_err),
    .crc_err_cnt (crc_err_cnt)
  );

endmodule

/* sdi_tb_stim.svh */
//----------------------------------------------------------------------
// Line generator tasks for the checker testbench, included inside the
// testbench module; they drive the DUT and update the model counts
//----------------------------------------------------------------------

`ifndef SDI_TB_STIM_SVH
`define SDI_TB_STIM_SVH

// random gap of disabled cycles, then one rx_ce cycle
task automatic next_word();
  int gap;
  int i;
  gap = $random(seed) & 3;
  for (i = 0; i < gap; i++)
  begin
    @(posedge clk);
    rx_ce <= 1'b0;
  end
  @(posedge clk);
  rx_ce <= 1'b1;
endtask

// one word of a line, pos counts from EAV = 1
task automatic send_word(input logic trs, input logic eav, input logic sav,
                         input sdi_words_t ds, input int pos);
  logic [NUM_DS-1:0] crc;
  crc = '0;
  if (pos == 8 || ($random(seed) & 7) == 0)
    crc = NUM_DS'($random(seed));                // stray flags off the slot too
  if (pos == 8 && !sd_line)
    model_crc_cnt += $countones(crc & mask);
  next_word();
  rx_trs            <= trs;
  rx_eav            <= eav;
  rx_sav            <= sav;
  rx_ds             <= ds;
  rx_crc_err        <= crc;
  rx_ln             <= line_ln;
  rx_active_streams <= line_code;
  exp_line          <= line_no;
  exp_mode          <= sd_line ? MODE_SD : line_mode;
endtask

//----------------------------------------------------------------------
// EAV, 10 blanking words, SAV, 16 active words
//----------------------------------------------------------------------
task automatic send_line();
  sdi_words_t ds;
  logic       bad;
  int         s;
  int         w;
  line_no   = line_no + 11'd1;
  line_code = 3'($random(seed));
  mask      = enabled_streams(line_code);
  for (s = 0; s < NUM_DS; s++)
  begin
    bad        = (($random(seed) & 3) == 0);
    line_ln[s] = bad ? (line_no ^ (11'd1 << ($random(seed) & 7))) : line_no;
    if (bad && mask[s] && !sd_line)
      model_line_cnt++;
  end
  for (s = 0; s < NUM_DS; s++)
    ds[s].raw = 10'h240;                         // EAV, h = 1
  send_word(1'b1, 1'b1, 1'b0, ds, 1);
  for (w = 2; w <= 11; w++)
  begin
    for (s = 0; s < NUM_DS; s++)
      ds[s].raw = 10'($random(seed));            // blanking is never checked
    send_word(1'b0, 1'b0, 1'b0, ds, w);
  end
  for (s = 0; s < NUM_DS; s++)
    ds[s].raw = 10'h200;                         // SAV with v = 0
  send_word(1'b1, 1'b0, 1'b1, ds, 12);
  for (w = 13; w <= 28; w++)
  begin
    for (s = 0; s < NUM_DS; s++)
    begin
      bad       = (($random(seed) & 7) == 0);
      ds[s].raw = (s % 2 == 0) ? PAT_EVEN : PAT_ODD;
      if (bad)
        ds[s].raw = ds[s].raw ^ (10'd1 << ($random(seed) & 7));
      if (bad && mask[s])
        model_data_cnt++;
    end
    send_word(1'b0, 1'b0, 1'b0, ds, w);
  end
endtask

`endif

/* sdi_rx_checker_tb.sv */
//----------------------------------------------------------------------
// Testbench for the SDI receive checker; random lines with corrupted
// words are compared against a model after every line
//----------------------------------------------------------------------

`timescale 1ns/1ps

module tb_sdi_rx_checker import sdi_video_pkg::*, sdi_check_pkg::*; ();

  logic                 clk;
  logic                 arst_n;
  logic                 rx_ce;
  logic                 rx_mode_locked;
  logic                 rx_t_locked;
  xport_fmt_t           rx_fmt;
  sdi_mode_t            rx_mode;
  logic                 rx_eav;
  logic                 rx_sav;
  logic                 rx_trs;
  sdi_words_t           rx_ds;
  sdi_lines_t           rx_ln;
  logic [NUM_DS-1:0]    rx_crc_err;
  logic [2:0]           rx_active_streams;
  xport_fmt_t           exp_fmt;
  sdi_mode_t            exp_mode;
  line_num_t            exp_line;
  logic [ERR_CNT_W-1:0] line_err_cnt;
  logic [ERR_CNT_W-1:0] data_err_cnt;
  logic [ERR_CNT_W-1:0] crc_err_cnt;
  logic                 fmt_done;
  logic                 fmt_err;
  logic                 mode_done;
  logic                 mode_err;

  // model state
  int                seed = 53424;
  int                fail_cnt;
  int                model_line_cnt;
  int                model_data_cnt;
  int                model_crc_cnt;
  bit                lock_done;
  bit                fmt_mismatch;
  bit                mode_mismatch;
  bit                sd_line;
  logic [NUM_DS-1:0] mask;
  logic [2:0]        line_code;
  line_num_t         line_no;
  sdi_lines_t        line_ln;
  sdi_mode_t         line_mode;

  sdi_rx_checker UUT (.*);

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // stream enables per active-streams code
  function automatic logic [NUM_DS-1:0] enabled_streams(input logic [2:0] code);
    logic [NUM_DS-1:0] m;
    if (code == 3'd1)
      m = 4'b0011;
    else if (code >= 3'd2 && code <= 3'd4)
      m = 4'b1111;
    else
      m = 4'b0001;                               // code 0 and codes 5 to 7
    return m;
  endfunction

  task automatic compare_value(input string what, input int got, input int expected);
    if (got != expected)
    begin
      fail_cnt++;
      $display("FAILED at %0t: %s is %0d, expected %0d", $time, what, got, expected);
      $display("=== FAIL ===");
      $fatal(1, "stopped at the first mismatch");
    end
  endtask

  task automatic check_all();
    compare_value("line_err_cnt", int'(line_err_cnt), model_line_cnt);
    compare_value("data_err_cnt", int'(data_err_cnt), model_data_cnt);
    compare_value("crc_err_cnt", int'(crc_err_cnt), model_crc_cnt);
    compare_value("fmt_done", int'(fmt_done), int'(lock_done));
    compare_value("fmt_err", int'(fmt_err), int'(lock_done & fmt_mismatch));
    compare_value("mode_done", int'(mode_done), int'(lock_done));
    compare_value("mode_err", int'(mode_err), int'(lock_done & mode_mismatch));
  endtask

  `include "sdi_tb_stim.svh"

  initial
  begin
    logic [8:0] fmt_bits;
    logic [8:0] exp_bits;
    bit         done_seen;
    int         waited;
    int         n;
    fail_cnt          = 0;
    model_line_cnt    = 0;
    model_data_cnt    = 0;
    model_crc_cnt     = 0;
    lock_done         = 1'b0;
    sd_line           = 1'b0;
    line_no           = 11'd20;
    line_ln           = '0;
    line_code         = 3'd0;
    mask              = 4'b0001;
    arst_n            <= 1'b0;
    rx_ce             <= 1'b0;
    rx_mode_locked    <= 1'b0;
    rx_t_locked       <= 1'b0;
    rx_fmt            <= '0;
    rx_mode           <= MODE_HD;
    rx_eav            <= 1'b0;
    rx_sav            <= 1'b0;
    rx_trs            <= 1'b0;
    rx_ds             <= '0;
    rx_ln             <= '0;
    rx_crc_err        <= '0;
    rx_active_streams <= '0;
    exp_fmt           <= '0;
    exp_mode          <= MODE_HD;
    exp_line          <= '0;
    repeat (10) @(posedge clk);
    arst_n <= 1'b1;
    @(negedge clk);
    check_all();

    //--------------------------------------------------------------------
    // lock, then one-shot format and mode compare
    //--------------------------------------------------------------------
    fmt_bits      = 9'($random(seed));
    fmt_mismatch  = (($random(seed) & 1) != 0);
    exp_bits      = fmt_mismatch ? (fmt_bits ^ (9'd1 << ($random(seed) & 7))) : fmt_bits;
    mode_mismatch = (($random(seed) & 1) != 0);
    line_mode     = mode_mismatch ? MODE_HD : MODE_3G;
    @(posedge clk);
    rx_fmt         <= xport_fmt_t'(fmt_bits);
    exp_fmt        <= xport_fmt_t'(exp_bits);
    rx_mode        <= MODE_3G;
    exp_mode       <= line_mode;
    rx_mode_locked <= 1'b1;
    rx_t_locked    <= 1'b1;
    waited    = 0;
    done_seen = 1'b0;
    while (!done_seen && waited < 100)
    begin
      next_word();
      @(negedge clk);
      done_seen = fmt_done & mode_done;
      waited++;
    end
    if (!done_seen)
    begin
      $display("timeout: fmt_done and mode_done did not rise after lock");
      $display("=== FAIL ===");
      $fatal(1, "lock wait timed out");
    end
    lock_done = 1'b1;
    check_all();

    // the last 15 lines run with SD expected
    for (n = 0; n < 45; n++)
    begin
      sd_line = (n >= 30);
      send_line();
      @(posedge clk);
      rx_ce <= 1'b0;
      @(negedge clk);
      check_all();
    end

    if (fail_cnt == 0)
    begin
      $display("=== PASS ===");
      $finish;
    end
    else
    begin
      $display("=== FAIL ===");
      $fatal(1, "checks failed");
    end
  end

endmodule

/* list.f */
+incdir+.
sdi_video_pkg.sv
sdi_check_pkg.sv
sdi_timing_if.sv
sdi_trs_tracker.sv
sdi_lock_monitor.sv
sdi_line_checker.sv
sdi_pattern_checker.sv
sdi_crc_checker.sv
sdi_rx_checker.sv
sdi_rx_checker_tb.sv

/* run.sh */
#!/bin/sh
# build the checker testbench with Verilator and run it
cd "$(dirname "$0")" &&
verilator --binary --timing -j 0 -f list.f --top-module tb_sdi_rx_checker -o tb_sim &&
./obj_dir/tb_sim | tee /dev/stderr | grep -q "^=== PASS ===$" &&
echo "simulation passed" && exit 0 ||
{ echo "simulation failed"; exit 1; }
